/* common/hdc_pkg.sv */
package hdc_pkg;

    // number of hypervector dimensions
    localparam int HV_DIM = 64;

    // parallel encoder cores feeding one sample
    localparam int NUM_CORES = 4;

    // one binary hypervector
    typedef logic [HV_DIM-1:0] hv_t;

    // one hypervector per core
    // core 0 sits in the lowest slot
    typedef hv_t [NUM_CORES-1:0] core_hv_t;

    // one sample as offered on the input handshake
    typedef struct packed {
        // encoder outputs, one per core
        core_hv_t               core_hv;
        // set bit means that core votes
        logic [NUM_CORES-1:0]   store;
        // closes the current bundle
        logic                   last;
    } sample_t;

    // bundled vector handed downstream
    typedef struct packed {
        // sign of every vote counter
        hv_t hv;
    } result_t;

endpackage

/* bundle/vote_counter.sv */
`timescale 1ns/100ps

module vote_counter
    import hdc_pkg::*;
#(
    parameter int CNT_W = 8
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 clear,
    input  logic [NUM_CORES-1:0] store,
    input  logic [NUM_CORES-1:0] core_bits,
    input  logic                 tie_bit,
    output logic                 sign_bit
);

    // headroom for count plus worst case vote of all cores
    localparam int SUM_W = CNT_W + $clog2(NUM_CORES + 1) + 1;
    localparam logic signed [SUM_W-1:0] VOTE_ONE = 1;
    // signed limits of a CNT_W bit count
    localparam logic signed [SUM_W-1:0] SAT_MAX = (1 <<< (CNT_W - 1)) - 1;
    localparam logic signed [SUM_W-1:0] SAT_MIN = -(1 <<< (CNT_W - 1));

    logic signed [CNT_W-1:0] count;
    logic signed [SUM_W-1:0] delta;
    logic signed [SUM_W-1:0] sum;
    logic signed [CNT_W-1:0] count_next;

    // net vote of this sample, one up or down per stored core
    always_comb begin
        delta = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            if (store[c]) begin
                if (core_bits[c]) begin
                    delta = delta + VOTE_ONE;
                end else begin
                    delta = delta - VOTE_ONE;
                end
            end
        end
    end

    // wide sum, then clamp into the counter range
    always_comb begin
        sum = count + delta;
        if (sum > SAT_MAX) begin
            count_next = SAT_MAX[CNT_W-1:0];
        end else if (sum < SAT_MIN) begin
            count_next = SAT_MIN[CNT_W-1:0];
        end else begin
            count_next = sum[CNT_W-1:0];
        end
    end

    // clear has priority over a store in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    // positive -> 1, negative -> 0, zero -> tie-break bit
    assign sign_bit = (count == '0) ? tie_bit : ~count[CNT_W-1];

endmodule

/* bundle/buffer_ctrl.sv */
`timescale 1ns/100ps

module buffer_ctrl
    import hdc_pkg::*;
#(
    parameter int CNT_W = 8
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 clear,
    input  logic                 capture,
    input  logic [NUM_CORES-1:0] store,
    input  core_hv_t             core_hv,
    input  hv_t                  tie_hv,
    output result_t              result
);

    // live sign of every counter
    hv_t sign_hv;

    generate
        for (genvar i = 0; i < HV_DIM; i++) begin : g_dim
            // dimension i of every core vector
            logic [NUM_CORES-1:0] core_bits;

            always_comb begin
                for (int c = 0; c < NUM_CORES; c++) begin
                    core_bits[c] = core_hv[c][i];
                end
            end

            vote_counter #(
                .CNT_W      (CNT_W)
            ) vote_counter_i (
                .clk        (clk),
                .arst_n     (arst_n),
                .clear      (clear),
                .store      (store),
                .core_bits  (core_bits),
                .tie_bit    (tie_hv[i]),
                .sign_bit   (sign_hv[i])
            );
        end
    endgenerate

    // output buffer
    // loads on the capture edge, while the counters still hold the bundle
    // the same edge clears them, so the signs must be taken here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (capture) begin
            result.hv <= sign_hv;
        end
    end

endmodule

/* src/bundle_sequencer.sv */
`timescale 1ns/100ps

module bundle_sequencer
    import hdc_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    // input side, four-phase
    input  logic                 in_req,
    output logic                 in_ack,
    input  logic [NUM_CORES-1:0] in_store,
    input  logic                 in_last,
    // output side, four-phase
    output logic                 out_req,
    input  logic                 out_ack,
    // strobes to the counter array
    output logic [NUM_CORES-1:0] store,
    output logic                 clear,
    output logic                 capture
);

    // fsm state codes
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_ACKED   = 3'd1;
    localparam logic [2:0] ST_CAPTURE = 3'd2;
    localparam logic [2:0] ST_OFFER   = 3'd3;
    localparam logic [2:0] ST_RELEASE = 3'd4;

    logic [2:0] state;
    logic       accept;

    // new sample taken on this edge
    // idle, request up, previous ack already back down
    assign accept = (state == ST_IDLE) && in_req && !in_ack;

    // one-cycle store strobe
    // counters add on the same edge that raises in_ack
    assign store = accept ? in_store : '0;

    // capture and clear share one pulse
    // buffer grabs the signs, counters restart from zero
    assign capture = (state == ST_CAPTURE);
    assign clear   = (state == ST_CAPTURE);

    // input ack
    // rises on accept, falls once req is seen low
    // runs on its own so a last sample can finish its handshake
    // while the bundle is being captured and offered
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_ack <= 1'b0;
        end else if (accept) begin
            in_ack <= 1'b1;
        end else if (in_ack && !in_req) begin
            in_ack <= 1'b0;
        end
    end

    // bundle fsm and output request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            out_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // last sample goes straight to capture
                    if (accept) begin
                        if (in_last) begin
                            state <= ST_CAPTURE;
                        end else begin
                            state <= ST_ACKED;
                        end
                    end
                end
                ST_ACKED: begin
                    // in_ack drops on this same edge
                    if (!in_req) begin
                        state <= ST_IDLE;
                    end
                end
                ST_CAPTURE: begin
                    // buffer is loaded on this edge
                    // offer follows one cycle later
                    state <= ST_OFFER;
                end
                ST_OFFER: begin
                    // raise the offer from a stable buffer
                    // then hold it until the sink acks
                    if (!out_req) begin
                        out_req <= 1'b1;
                    end else if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    // no new input until the sink drops its ack
                    if (!out_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state   <= ST_IDLE;
                    out_req <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* src/hdc_bundle_top.sv */
`timescale 1ns/100ps

module hdc_bundle_top
    import hdc_pkg::*;
#(
    // vote counter width in bits
    parameter int CNT_W = 8
) (
    input  logic    clk,
    input  logic    arst_n,
    // sample input, four-phase
    input  logic    in_req,
    output logic    in_ack,
    input  sample_t in_sample,
    // fixed tie-break vector, held stable by the source
    input  hv_t     tie_hv,
    // bundled result, four-phase
    output logic    out_req,
    input  logic    out_ack,
    output result_t out_result
);

    // strobes from sequencer to counter array
    logic [NUM_CORES-1:0] store_mask;
    logic                 clear;
    logic                 capture;

    // handshakes and strobe timing
    bundle_sequencer bundle_sequencer_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_store   (in_sample.store),
        .in_last    (in_sample.last),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .store      (store_mask),
        .clear      (clear),
        .capture    (capture)
    );

    // vote counters and output buffer
    // core vectors go in unregistered, stable while in_req is high
    buffer_ctrl #(
        .CNT_W      (CNT_W)
    ) buffer_ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .clear      (clear),
        .capture    (capture),
        .store      (store_mask),
        .core_hv    (in_sample.core_hv),
        .tie_hv     (tie_hv),
        .result     (out_result)
    );

endmodule

/* test/hdc_bundle_sva.sv */
`timescale 1ns/100ps

module hdc_bundle_sva
    import hdc_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input logic    in_ack,
    input sample_t in_sample,
    input logic    out_req,
    input logic    out_ack
);

    // no accept while a result is offered or still acked
    property no_accept_while_output_busy;
        @(posedge clk) disable iff (!arst_n)
            $rose(in_ack) |-> !$past(out_req) && !$past(out_ack);
    endproperty

    // offer held until the sink answers
    property out_req_held_until_ack;
        @(posedge clk) disable iff (!arst_n)
            out_req && !out_ack |=> out_req;
    endproperty

    // accept of a last sample, capture, then offer
    property last_to_out_req;
        @(posedge clk) disable iff (!arst_n)
            $rose(in_ack) && in_sample.last |-> ##2 $rose(out_req);
    endproperty

    assert property (no_accept_while_output_busy)
        else $error("in_ack rose while the output handshake was busy");

    assert property (out_req_held_until_ack)
        else $error("out_req dropped before out_ack");

    assert property (last_to_out_req)
        else $error("out_req did not rise 2 cycles after a last accept");

endmodule

bind hdc_bundle_top hdc_bundle_sva hdc_bundle_sva_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_ack     (in_ack),
    .in_sample  (in_sample),
    .out_req    (out_req),
    .out_ack    (out_ack)
);

/* test/hdc_bundle_tb.sv */
`timescale 1ns/100ps

module hdc_bundle_tb
    import hdc_pkg::*;
();

    localparam int CNT_W = 8;
    // signed limits of one vote counter
    localparam int CNT_MAX = (1 << (CNT_W - 1)) - 1;
    localparam int CNT_MIN = -(1 << (CNT_W - 1));
    localparam logic [31:0] LFSR_SEED = 32'd72608;
    // watchdog budget
    localparam int NUM_SAMPLES = 65;
    localparam int SAMPLE_CYCLES = 60;
    localparam int MARGIN_CYCLES = 200;
    // sink stall in the back-pressure test
    localparam int ACK_DELAY = 40;

    logic    clk;
    logic    arst_n;
    logic    in_req;
    logic    in_ack;
    sample_t in_sample;
    hv_t     tie_hv;
    logic    out_req;
    logic    out_ack;
    result_t out_result;

    logic [31:0] lfsr_state;
    // reference vote counts, one per dimension
    int          model_cnt [HV_DIM];

    always #2 clk = ~clk;

    hdc_bundle_top #(
        .CNT_W      (CNT_W)
    ) hdc_bundle_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_sample  (in_sample),
        .tie_hv     (tie_hv),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_result (out_result)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic model_clear();
        for (int d = 0; d < HV_DIM; d++) begin
            model_cnt[d] = 0;
        end
    endtask

    // whole sample summed first, then clamped once
    task automatic model_add(input sample_t s);
        int net;
        for (int d = 0; d < HV_DIM; d++) begin
            net = model_cnt[d];
            for (int c = 0; c < NUM_CORES; c++) begin
                if (s.store[c]) begin
                    net = s.core_hv[c][d] ? net + 1 : net - 1;
                end
            end
            if (net > CNT_MAX) begin
                net = CNT_MAX;
            end else if (net < CNT_MIN) begin
                net = CNT_MIN;
            end
            model_cnt[d] = net;
        end
    endtask

    // sign per dimension, tie bit on a zero count
    function automatic hv_t model_result(input hv_t tie);
        hv_t r;
        for (int d = 0; d < HV_DIM; d++) begin
            if (model_cnt[d] > 0) begin
                r[d] = 1'b1;
            end else if (model_cnt[d] < 0) begin
                r[d] = 1'b0;
            end else begin
                r[d] = tie[d];
            end
        end
        return r;
    endfunction

    task automatic random_sample(input logic [NUM_CORES-1:0] store, input logic last,
                                 output sample_t s);
        logic [63:0] v;
        for (int c = 0; c < NUM_CORES; c++) begin
            random_bits(HV_DIM, v);
            s.core_hv[c] = v;
        end
        s.store = store;
        s.last  = last;
    endtask

    // new tie vector while the DUT sits idle
    task automatic set_tie(output hv_t tie);
        logic [63:0] v;
        random_bits(HV_DIM, v);
        tie = v;
        @(posedge clk);
        tie_hv <= tie;
    endtask

    task automatic send_sample(input sample_t s);
        @(posedge clk);
        in_sample <= s;
        in_req    <= 1'b1;
        do begin
            @(negedge clk);
        end while (!in_ack);
        @(posedge clk);
        in_req <= 1'b0;
        do begin
            @(negedge clk);
        end while (in_ack);
    endtask

    // no input may be accepted while the result waits for the sink
    task automatic take_result(input int delay, output result_t r);
        do begin
            @(negedge clk);
        end while (!out_req);
        r = out_result;
        repeat (delay) begin
            @(negedge clk);
            check_value("in_ack", 64'(1'b0), 64'(in_ack));
        end
        @(posedge clk);
        out_ack <= 1'b1;
        do begin
            @(negedge clk);
        end while (out_req);
        @(posedge clk);
        out_ack <= 1'b0;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_value("in_ack", 64'(1'b0), 64'(in_ack));
        check_value("out_req", 64'(1'b0), 64'(out_req));
        check_value("out_result", 64'(1'b0), out_result.hv);
    endtask

    task automatic test_single_core();
        logic [63:0] r;
        hv_t         tie;
        sample_t     s;
        result_t     res;
        int          idx;
        random_bits(2, r);
        idx = int'(r[1:0]);
        set_tie(tie);
        random_sample(NUM_CORES'(1) << idx, 1'b1, s);
        model_clear();
        model_add(s);
        send_sample(s);
        take_result(2, res);
        check_value("out_result", s.core_hv[idx], res.hv);
        check_value("out_result", model_result(tie), res.hv);
    endtask

    // 16 votes per dimension, so zero counts show up
    task automatic test_random_bundles();
        hv_t     tie;
        sample_t s;
        result_t res;
        for (int b = 0; b < 3; b++) begin
            set_tie(tie);
            model_clear();
            for (int k = 0; k < 4; k++) begin
                random_sample('1, k == 3, s);
                model_add(s);
                send_sample(s);
            end
            take_result(b + 1, res);
            check_value("out_result", model_result(tie), res.hv);
        end
    endtask

    // masked cores outvote core 0 if they were counted
    task automatic test_store_mask();
        hv_t     tie;
        sample_t s;
        result_t res;
        set_tie(tie);
        model_clear();
        for (int k = 0; k < 3; k++) begin
            random_sample(4'b0001, k == 2, s);
            for (int c = 1; c < NUM_CORES; c++) begin
                s.core_hv[c] = ~s.core_hv[0];
            end
            model_add(s);
            send_sample(s);
        end
        take_result(3, res);
        check_value("out_result", model_result(tie), res.hv);
    endtask

    task automatic test_back_pressure();
        hv_t     tie;
        hv_t     exp_first;
        hv_t     exp_second;
        sample_t samples [6];
        result_t res_first;
        result_t res_second;
        set_tie(tie);
        model_clear();
        for (int k = 0; k < 6; k++) begin
            if (k == 3) begin
                exp_first = model_result(tie);
                model_clear();
            end
            random_sample('1, k == 2 || k == 5, samples[k]);
            model_add(samples[k]);
        end
        exp_second = model_result(tie);
        // source keeps offering while the sink stalls
        fork
            begin
                for (int k = 0; k < 6; k++) begin
                    send_sample(samples[k]);
                end
            end
            begin
                take_result(ACK_DELAY, res_first);
                take_result(ACK_DELAY, res_second);
            end
        join
        check_value("out_result", exp_first, res_first.hv);
        check_value("out_result", exp_second, res_second.hv);
    endtask

    // 160 up votes would wrap an 8 bit count
    task automatic test_saturation();
        hv_t     tie;
        sample_t s;
        result_t res;
        set_tie(tie);
        model_clear();
        for (int k = 0; k < 43; k++) begin
            s.core_hv = (k < 40) ? '1 : '0;
            s.store   = '1;
            s.last    = (k == 42);
            model_add(s);
            send_sample(s);
        end
        take_result(2, res);
        check_value("out_result", {HV_DIM{1'b1}}, res.hv);
        check_value("out_result", model_result(tie), res.hv);
    endtask

    initial begin
        repeat (NUM_SAMPLES * SAMPLE_CYCLES + MARGIN_CYCLES) @(posedge clk);
        $display("timeout: the DUT stopped answering a handshake in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        in_req     = 1'b0;
        in_sample  = '0;
        tie_hv     = '0;
        out_ack    = 1'b0;
        lfsr_state = LFSR_SEED;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_single_core();
        test_random_bundles();
        test_store_mask();
        test_back_pressure();
        test_saturation();
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* hdc_bundle_top.f */
common/hdc_pkg.sv
bundle/vote_counter.sv
bundle/buffer_ctrl.sv
src/bundle_sequencer.sv
src/hdc_bundle_top.sv
test/hdc_bundle_sva.sv
test/hdc_bundle_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bundling testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module hdc_bundle_tb \
    -f hdc_bundle_top.f \
    -o hdc_bundle_sim

# the simulator exits non-zero on $fatal, keep its output anyway
sim_out=$(./obj_dir/hdc_bundle_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'TEST PASSED'; then
    exit 0
fi
exit 1
